//--- hw/icacheCtrl.sv
`default_nettype none

module icacheCtrl import icachePkg::*; #(
  parameter logic [15:0] VICTIM_SEED = 16'hACE1
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        reqValid_i,
  input  wire addrT  reqAddr_i,
  output logic       reqReady_o,
  output logic       respValid_o,
  output wordT       respData_o,
  input  wire        respReady_i,
  output idxT        lookupIdx_o,
  output tagT        lookupTag_o,
  input  wire        hit_i,
  input  wire        hitWay_i,
  input  wire [1:0]  wayValid_i,
  output logic       fillEn_o,
  output logic       fillWay_o,
  output idxT        fillIdx_o,
  output tagT        fillTag_o,
  output logic       way0RdEn_o,
  output logic       way1RdEn_o,
  output idxT        rdIdx_o,
  output logic       way0WrEn_o,
  output logic       way1WrEn_o,
  output lineT       wrLine_o,
  input  wire lineT  way0Line_i,
  input  wire lineT  way1Line_i,
  output logic       startFill_o,
  output addrT       fillAddr_o,
  input  wire        fillDone_i,
  input  wire lineT  fillLine_i
);

  ctrlStateT   stateQ;
  ctrlStateT   stateD;
  addrT        reqAddrQ;
  logic [15:0] lfsrQ;
  logic        outFree;
  logic        reqAccept;
  logic        loadHit;
  logic        loadFill;
  logic        victimWay;
  beatCntT     wordSel;
  lineT        hitLine;
  wordT        hitWord;
  wordT        fillWord;

  // output slot is free when empty or draining this cycle
  assign outFree   = !respValid_o || respReady_i;
  assign reqAccept = reqValid_i && reqReady_o;

  always_comb begin
    case (stateQ)
      IDLE:    reqReady_o = outFree;
      LOOKUP:  reqReady_o = hit_i && outFree;
      REPLY:   reqReady_o = outFree;
      default: reqReady_o = 1'b0;
    endcase
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      IDLE: begin
        if (reqAccept) begin
          stateD = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!hit_i) begin
          stateD = MISS;
        end else if (outFree) begin
          stateD = reqAccept ? LOOKUP : IDLE;
        end
      end
      MISS:  stateD = FILL;
      FILL: begin
        if (fillDone_i) begin
          stateD = REPLY;
        end
      end
      REPLY: begin
        if (outFree) begin
          stateD = reqAccept ? LOOKUP : IDLE;
        end
      end
      default: stateD = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= IDLE;
    end else begin
      stateQ <= stateD;
    end
  end

  always_ff @(posedge clk) begin
    if (reqAccept) begin
      reqAddrQ <= reqAddr_i;
    end
  end

  // address fields of the request in flight
  assign wordSel     = reqAddrQ[OFF_W-1:OFF_W-2];
  assign lookupIdx_o = reqAddrQ[OFF_W +: IDX_W];
  assign lookupTag_o = reqAddrQ[ADDR_W-1 -: TAG_W];

  // both ways read on accept, compared next cycle
  assign way0RdEn_o = reqAccept;
  assign way1RdEn_o = reqAccept;
  assign rdIdx_o    = reqAddr_i[OFF_W +: IDX_W];

  assign hitLine  = hitWay_i ? way1Line_i : way0Line_i;
  assign hitWord  = hitLine[wordSel*WORD_W +: WORD_W];
  assign fillWord = fillLine_i[wordSel*WORD_W +: WORD_W];

  assign loadHit  = (stateQ == LOOKUP) && hit_i && outFree;
  assign loadFill = (stateQ == REPLY) && outFree;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      respValid_o <= 1'b0;
    end else if (loadHit || loadFill) begin
      respValid_o <= 1'b1;
    end else if (respReady_i) begin
      respValid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (loadHit) begin
      respData_o <= hitWord;
    end else if (loadFill) begin
      respData_o <= fillWord;
    end
  end

  // refill request
  assign startFill_o = (stateQ == MISS);
  assign fillAddr_o  = {reqAddrQ[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

  // victim lfsr, taps 16 14 13 11, one step per refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsrQ <= VICTIM_SEED;
    end else if (startFill_o) begin
      lfsrQ <= {lfsrQ[14:0], lfsrQ[15] ^ lfsrQ[13] ^ lfsrQ[12] ^ lfsrQ[10]};
    end
  end

  // empty ways first, then random
  always_comb begin
    if (!wayValid_i[0]) begin
      victimWay = 1'b0;
    end else if (!wayValid_i[1]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lfsrQ[0];
    end
  end

  // line and tag written together when the burst completes
  assign fillEn_o   = (stateQ == FILL) && fillDone_i;
  assign fillWay_o  = victimWay;
  assign fillIdx_o  = lookupIdx_o;
  assign fillTag_o  = lookupTag_o;
  assign way0WrEn_o = fillEn_o && !victimWay;
  assign way1WrEn_o = fillEn_o && victimWay;
  assign wrLine_o   = fillLine_i;

endmodule

`default_nettype wire

//--- hw/icacheDataRam.sv
`default_nettype none

module icacheDataRam import icachePkg::*; (
  input  wire       clk,
  input  wire       rdEn_i,
  input  wire idxT  rdIdx_i,
  input  wire       wrEn_i,
  input  wire idxT  wrIdx_i,
  input  wire lineT wrLine_i,
  output lineT      rdLine_o
);

  // one way, one line per set
  lineT lineMem [2**IDX_W];

  // single port macro behavior, write wins over read
  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      lineMem[wrIdx_i] <= wrLine_i;
    end else if (rdEn_i) begin
      rdLine_o <= lineMem[rdIdx_i];
    end
  end

endmodule

`default_nettype wire

//--- hw/icachePkg.sv
`default_nettype none

package icachePkg;

  // fixed geometry of the fetch cache
  localparam int ADDR_W = 32;
  localparam int WORD_W = 64;
  localparam int IDX_W  = 6;
  localparam int OFF_W  = 5;
  localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;
  localparam int BEATS  = 4;
  localparam int LINE_W = BEATS * WORD_W;

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [WORD_W-1:0] wordT;
  typedef logic [TAG_W-1:0]  tagT;
  typedef logic [IDX_W-1:0]  idxT;
  typedef logic [LINE_W-1:0] lineT;

  // also used as the word select within a line
  typedef logic [1:0] beatCntT;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS,
    FILL,
    REPLY
  } ctrlStateT;

endpackage

`default_nettype wire

//--- hw/icacheRefill.sv
`default_nettype none

module icacheRefill import icachePkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        startFill_i,
  input  wire addrT  fillAddr_i,
  output logic       fillDone_o,
  output lineT       fillLine_o,
  output logic       memArValid_o,
  input  wire        memArReady_i,
  output addrT       memArAddr_o,
  output logic [7:0] memArLen_o,
  input  wire        memRValid_i,
  input  wire wordT  memRData_i,
  input  wire        memRLast_i,
  output logic       memRReady_o
);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_ADDR,
    RF_DATA
  } refillStateT;

  refillStateT stateQ;
  addrT        lineAddrQ;
  beatCntT     beatQ;
  lineT        lineBufQ;
  logic        beatTake;

  assign beatTake = (stateQ == RF_DATA) && memRValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ     <= RF_IDLE;
      beatQ      <= '0;
      fillDone_o <= 1'b0;
    end else begin
      // done one cycle after the last beat lands
      fillDone_o <= beatTake && memRLast_i;
      case (stateQ)
        RF_IDLE: begin
          if (startFill_i) begin
            stateQ <= RF_ADDR;
            beatQ  <= '0;
          end
        end
        RF_ADDR: begin
          if (memArReady_i) begin
            stateQ <= RF_DATA;
          end
        end
        RF_DATA: begin
          if (beatTake) begin
            beatQ <= beatQ + beatCntT'(1);
            if (memRLast_i) begin
              stateQ <= RF_IDLE;
            end
          end
        end
        default: stateQ <= RF_IDLE;
      endcase
    end
  end

  // burst address and line buffer
  always_ff @(posedge clk) begin
    if (stateQ == RF_IDLE && startFill_i) begin
      lineAddrQ <= {fillAddr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    end
    if (beatTake) begin
      lineBufQ[beatQ*WORD_W +: WORD_W] <= memRData_i;
    end
  end

  assign memArValid_o = (stateQ == RF_ADDR);
  assign memArAddr_o  = lineAddrQ;
  assign memArLen_o   = 8'(BEATS - 1);
  assign memRReady_o  = (stateQ == RF_DATA);
  assign fillLine_o   = lineBufQ;

endmodule

`default_nettype wire

//--- hw/icacheTagStore.sv
`default_nettype none

module icacheTagStore import icachePkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire idxT   lookupIdx_i,
  input  wire tagT   lookupTag_i,
  input  wire        fillEn_i,
  input  wire        fillWay_i,
  input  wire idxT   fillIdx_i,
  input  wire tagT   fillTag_i,
  output logic       hit_o,
  output logic       hitWay_o,
  output logic [1:0] wayValid_o
);

  tagT         tagMem [2][2**IDX_W];
  logic [63:0] validQ [2];
  logic        way0Hit;
  logic        way1Hit;

  // valid bits start clear, tags do not matter until valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ[0] <= '0;
      validQ[1] <= '0;
    end else if (fillEn_i) begin
      validQ[fillWay_i][fillIdx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagMem[fillWay_i][fillIdx_i] <= fillTag_i;
    end
  end

  assign wayValid_o = {validQ[1][lookupIdx_i], validQ[0][lookupIdx_i]};

  // compare both ways of the selected set
  assign way0Hit = wayValid_o[0] && (tagMem[0][lookupIdx_i] == lookupTag_i);
  assign way1Hit = wayValid_o[1] && (tagMem[1][lookupIdx_i] == lookupTag_i);

  assign hit_o    = way0Hit || way1Hit;
  // a tag lives in at most one way of a set
  assign hitWay_o = way1Hit;

endmodule

`default_nettype wire

//--- hw/icacheTop.sv
`default_nettype none

module icacheTop import icachePkg::*; #(
  parameter logic [15:0] VICTIM_SEED = 16'hACE1
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        reqValid_i,
  input  wire addrT  reqAddr_i,
  output logic       reqReady_o,
  output logic       respValid_o,
  output wordT       respData_o,
  input  wire        respReady_i,
  output logic       memArValid_o,
  input  wire        memArReady_i,
  output addrT       memArAddr_o,
  output logic [7:0] memArLen_o,
  input  wire        memRValid_i,
  input  wire wordT  memRData_i,
  input  wire        memRLast_i,
  output logic       memRReady_o
);

  idxT        lookupIdx;
  tagT        lookupTag;
  logic       hit;
  logic       hitWay;
  logic [1:0] wayValid;
  logic       fillEn;
  logic       fillWay;
  idxT        fillIdx;
  tagT        fillTag;
  logic       way0RdEn;
  logic       way1RdEn;
  idxT        rdIdx;
  logic       way0WrEn;
  logic       way1WrEn;
  lineT       wrLine;
  lineT       way0Line;
  lineT       way1Line;
  logic       startFill;
  addrT       fillAddr;
  logic       fillDone;
  lineT       fillLine;

  icacheCtrl #(
    .VICTIM_SEED(VICTIM_SEED)
  ) ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .reqValid_i (reqValid_i),
    .reqAddr_i  (reqAddr_i),
    .reqReady_o (reqReady_o),
    .respValid_o(respValid_o),
    .respData_o (respData_o),
    .respReady_i(respReady_i),
    .lookupIdx_o(lookupIdx),
    .lookupTag_o(lookupTag),
    .hit_i      (hit),
    .hitWay_i   (hitWay),
    .wayValid_i (wayValid),
    .fillEn_o   (fillEn),
    .fillWay_o  (fillWay),
    .fillIdx_o  (fillIdx),
    .fillTag_o  (fillTag),
    .way0RdEn_o (way0RdEn),
    .way1RdEn_o (way1RdEn),
    .rdIdx_o    (rdIdx),
    .way0WrEn_o (way0WrEn),
    .way1WrEn_o (way1WrEn),
    .wrLine_o   (wrLine),
    .way0Line_i (way0Line),
    .way1Line_i (way1Line),
    .startFill_o(startFill),
    .fillAddr_o (fillAddr),
    .fillDone_i (fillDone),
    .fillLine_i (fillLine)
  );

  icacheTagStore tagStore (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookupIdx_i(lookupIdx),
    .lookupTag_i(lookupTag),
    .fillEn_i   (fillEn),
    .fillWay_i  (fillWay),
    .fillIdx_i  (fillIdx),
    .fillTag_i  (fillTag),
    .hit_o      (hit),
    .hitWay_o   (hitWay),
    .wayValid_o (wayValid)
  );

  // fill index doubles as the line write index
  icacheDataRam way0Ram (
    .clk     (clk),
    .rdEn_i  (way0RdEn),
    .rdIdx_i (rdIdx),
    .wrEn_i  (way0WrEn),
    .wrIdx_i (fillIdx),
    .wrLine_i(wrLine),
    .rdLine_o(way0Line)
  );

  icacheDataRam way1Ram (
    .clk     (clk),
    .rdEn_i  (way1RdEn),
    .rdIdx_i (rdIdx),
    .wrEn_i  (way1WrEn),
    .wrIdx_i (fillIdx),
    .wrLine_i(wrLine),
    .rdLine_o(way1Line)
  );

  icacheRefill refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .startFill_i (startFill),
    .fillAddr_i  (fillAddr),
    .fillDone_o  (fillDone),
    .fillLine_o  (fillLine),
    .memArValid_o(memArValid_o),
    .memArReady_i(memArReady_i),
    .memArAddr_o (memArAddr_o),
    .memArLen_o  (memArLen_o),
    .memRValid_i (memRValid_i),
    .memRData_i  (memRData_i),
    .memRLast_i  (memRLast_i),
    .memRReady_o (memRReady_o)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tbIcache -f verilog.f -o simIcache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simIcache > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

//--- test/memRdModel.sv
`default_nettype none

module memRdModel import icachePkg::*; #(
  parameter int MEM_STALL = 2
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        arValid_i,
  input  wire addrT  arAddr_i,
  input  wire [7:0]  arLen_i,
  output logic       arReady_o,
  output logic       rValid_o,
  output wordT       rData_o,
  output logic       rLast_o,
  input  wire        rReady_i,
  output int         burstCount_o,
  output addrT       lastArAddr_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic       arFire;
  logic       rFire;
  logic [7:0] burstLenQ;
  logic [7:0] beatsLeft;
  addrT       beatAddr;
  int         stallCnt;

  // upper half is the inverted byte address of the beat
  function automatic wordT beatWord(input addrT a);
    return {~a, a};
  endfunction

  // handshakes as the cache sees them at the rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arFire       <= 1'b0;
      rFire        <= 1'b0;
      burstCount_o <= 0;
      lastArAddr_o <= '0;
      burstLenQ    <= '0;
    end else begin
      arFire <= arValid_i && arReady_o;
      rFire  <= rValid_o && rReady_i;
      if (arValid_i && arReady_o) begin
        burstCount_o <= burstCount_o + 1;
        lastArAddr_o <= arAddr_i;
        burstLenQ    <= arLen_i;
      end
    end
  end

  // memory side outputs move on the falling edge
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arReady_o <= 1'b0;
      rValid_o  <= 1'b0;
      rData_o   <= '0;
      rLast_o   <= 1'b0;
      beatAddr  <= '0;
      beatsLeft <= '0;
      stallCnt  <= 0;
    end else if (arFire) begin
      arReady_o <= 1'b0;
      stallCnt  <= 0;
      rValid_o  <= 1'b1;
      rData_o   <= beatWord(lastArAddr_o);
      rLast_o   <= (burstLenQ == 8'd0);
      beatAddr  <= lastArAddr_o;
      beatsLeft <= burstLenQ;
    end else if (rFire) begin
      if (rLast_o) begin
        rValid_o <= 1'b0;
        rLast_o  <= 1'b0;
      end else begin
        beatAddr  <= beatAddr + 32'd8;
        rData_o   <= beatWord(beatAddr + 32'd8);
        beatsLeft <= beatsLeft - 8'd1;
        rLast_o   <= (beatsLeft == 8'd1);
      end
    end else if (arValid_i && !arReady_o && !rValid_o) begin
      // address phase held off for MEM_STALL cycles
      if (stallCnt >= MEM_STALL) begin
        arReady_o <= 1'b1;
      end else begin
        stallCnt <= stallCnt + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tbIcache.sv
`default_nettype none

module tbIcache import icachePkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TABLE   = 15;
  localparam int NUM_RAND    = 40;
  localparam int NUM_TOTAL   = NUM_TABLE + NUM_RAND;
  localparam int WATCHDOG_NS = NUM_TOTAL * 40 * CLK_PERIOD;

  typedef struct packed {
    addrT       addr;
    logic [7:0] stall;
    logic [1:0] burstInc;
  } entryT;

  logic       clk;
  logic       rst_n;
  logic       reqValid;
  addrT       reqAddr;
  logic       reqReady;
  logic       respValid;
  wordT       respData;
  logic       respReady;
  logic       memArValid;
  logic       memArReady;
  addrT       memArAddr;
  logic [7:0] memArLen;
  logic       memRValid;
  wordT       memRData;
  logic       memRLast;
  logic       memRReady;
  int         burstCount;
  addrT       lastArAddr;

  entryT       stimTable [NUM_TABLE];
  entryT       runList [NUM_TOTAL];
  addrT        seenLines [$];
  logic        reqFire;
  logic        respFire;
  wordT        respFireData;
  int          respCount;
  int          errors;
  logic [31:0] lcgState;

  icacheTop #(
    .VICTIM_SEED(16'h1D0F)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid),
    .reqAddr_i   (reqAddr),
    .reqReady_o  (reqReady),
    .respValid_o (respValid),
    .respData_o  (respData),
    .respReady_i (respReady),
    .memArValid_o(memArValid),
    .memArReady_i(memArReady),
    .memArAddr_o (memArAddr),
    .memArLen_o  (memArLen),
    .memRValid_i (memRValid),
    .memRData_i  (memRData),
    .memRLast_i  (memRLast),
    .memRReady_o (memRReady)
  );

  memRdModel #(
    .MEM_STALL(2)
  ) mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .arValid_i   (memArValid),
    .arAddr_i    (memArAddr),
    .arLen_i     (memArLen),
    .arReady_o   (memArReady),
    .rValid_o    (memRValid),
    .rData_o     (memRData),
    .rLast_o     (memRLast),
    .rReady_i    (memRReady),
    .burstCount_o(burstCount),
    .lastArAddr_o(lastArAddr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fetch handshakes taken at the rising edge and read back on the falling edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqFire   <= 1'b0;
      respFire  <= 1'b0;
      respCount <= 0;
    end else begin
      reqFire      <= reqValid && reqReady;
      respFire     <= respValid && respReady;
      respFireData <= respData;
      if (respValid && respReady) begin
        respCount <= respCount + 1;
      end
    end
  end

  // word of a fetch address by the memory data rule
  function automatic wordT expectedWord(input addrT a);
    addrT beatAddr;
    beatAddr = {a[ADDR_W-1:3], 3'b000};
    return {~beatAddr, beatAddr};
  endfunction

  function automatic addrT lineOf(input addrT a);
    return {a[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  endfunction

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic bit lineSeen(input addrT line);
    foreach (seenLines[k]) begin
      if (seenLines[k] == line) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic reportMismatch(input string sigName, input wordT expVal, input wordT gotVal);
    errors++;
    $display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, sigName, expVal, gotVal);
  endtask

  task automatic checkResetState();
    if (reqReady !== 1'b1) reportMismatch("reqReady_o", 64'd1, 64'(reqReady));
    if (respValid !== 1'b0) reportMismatch("respValid_o", 64'd0, 64'(respValid));
    if (memArValid !== 1'b0) reportMismatch("memArValid_o", 64'd0, 64'(memArValid));
    if (memRReady !== 1'b0) reportMismatch("memRReady_o", 64'd0, 64'(memRReady));
  endtask

  task automatic driveRequests();
    for (int i = 0; i < NUM_TOTAL; i++) begin
      reqValid = 1'b1;
      reqAddr  = runList[i].addr;
      @(negedge clk);
      while (!reqFire) @(negedge clk);
    end
    reqValid = 1'b0;
  endtask

  task automatic collectResponses();
    wordT held;
    wordT expData;
    int   prevBursts;
    prevBursts = 0;
    for (int i = 0; i < NUM_TOTAL; i++) begin
      respReady = (runList[i].stall == 8'd0);
      while (!respValid) @(negedge clk);
      if (runList[i].stall != 8'd0) begin
        // response must hold while the fetch stage stalls
        held = respData;
        repeat (runList[i].stall) begin
          @(negedge clk);
          if (!respValid) begin
            errors++;
            $display("response %0d withdrawn under back-pressure at %0d ns", i, $time);
          end
          if (respData !== held) reportMismatch("respData_o", held, respData);
          if (reqReady !== 1'b0) reportMismatch("reqReady_o", 64'd0, 64'(reqReady));
        end
        respReady = 1'b1;
      end
      @(negedge clk);
      while (!respFire) @(negedge clk);
      expData = expectedWord(runList[i].addr);
      if (respFireData !== expData) reportMismatch("respData_o", expData, respFireData);
      if (!lineSeen(lineOf(runList[i].addr))) begin
        seenLines.push_back(lineOf(runList[i].addr));
      end
      if (i < NUM_TABLE) begin
        if (burstCount - prevBursts != int'(runList[i].burstInc)) begin
          reportMismatch("burstCount", 64'(runList[i].burstInc), 64'(burstCount - prevBursts));
        end
        if (runList[i].burstInc == 2'd1 && lastArAddr !== lineOf(runList[i].addr)) begin
          reportMismatch("memArAddr_o", 64'(lineOf(runList[i].addr)), 64'(lastArAddr));
        end
        if (runList[i].burstInc == 2'd1 && memArLen !== 8'd3) begin
          reportMismatch("memArLen_o", 64'd3, 64'(memArLen));
        end
      end
      if (burstCount > seenLines.size()) begin
        errors++;
        $display("more bursts (%0d) than distinct lines requested (%0d) at %0d ns",
                 burstCount, seenLines.size(), $time);
      end
      prevBursts = burstCount;
    end
    respReady = 1'b0;
  endtask

  initial begin
    rst_n     = 1'b0;
    reqValid  = 1'b0;
    reqAddr   = '0;
    respReady = 1'b0;
    errors    = 0;

    // address, respReady stall cycles, expected new bursts
    // lines A, B and C share index 5 with tags 1, 2 and 3
    stimTable = '{
      '{32'h0000_08A8, 8'd0, 2'd1},
      '{32'h0000_08A0, 8'd0, 2'd0},
      '{32'h0000_08B0, 8'd0, 2'd0},
      '{32'h0000_08B8, 8'd0, 2'd0},
      '{32'h0000_08A8, 8'd0, 2'd0},
      '{32'h0000_10A0, 8'd0, 2'd1},
      '{32'h0000_10B8, 8'd0, 2'd0},
      '{32'h0000_08A0, 8'd0, 2'd0},
      '{32'h0000_10A8, 8'd6, 2'd0},
      '{32'h0000_08B0, 8'd0, 2'd0},
      '{32'h2000_0040, 8'd5, 2'd1},
      '{32'h2000_0048, 8'd0, 2'd0},
      '{32'h0000_18A0, 8'd0, 2'd1},
      '{32'h0000_18B8, 8'd0, 2'd0},
      '{32'h2000_0058, 8'd3, 2'd0}
    };

    // random fetches inside a 2 KB window with one line per set
    lcgState = 32'd68534;
    for (int i = 0; i < NUM_TOTAL; i++) begin
      if (i < NUM_TABLE) begin
        runList[i] = stimTable[i];
      end else begin
        lcgState = lcgNext(lcgState);
        runList[i].addr     = {21'h080000, lcgState[23:16], 3'b000};
        runList[i].stall    = {6'b000000, lcgState[29:28]};
        runList[i].burstInc = 2'd0;
      end
    end

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    checkResetState();

    fork
      driveRequests();
      collectResponses();
    join

    // nothing more may come out
    repeat (10) begin
      @(negedge clk);
      if (respValid) begin
        errors++;
        $display("unexpected extra response at %0d ns", $time);
        break;
      end
    end

    $display("responses: %0d, bursts: %0d, errors: %0d", respCount, burstCount, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still busy after %0d ns", WATCHDOG_NS);
    $display("responses: %0d, bursts: %0d, errors: %0d", respCount, burstCount, errors + 1);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/icachePkg.sv
hw/icacheTagStore.sv
hw/icacheDataRam.sv
hw/icacheRefill.sv
hw/icacheCtrl.sv
hw/icacheTop.sv
test/memRdModel.sv
test/tbIcache.sv
